/* hw/i8008_pkg.sv */
`default_nettype none

package i8008_pkg;

  // datapath widths
  localparam int word_w  = 8;
  localparam int addr_w  = 14;
  localparam int state_w = 3;
  localparam int sel_w   = 3;

  // 8008 state output encodings
  localparam logic [2:0] st_t1      = 3'b010;
  localparam logic [2:0] st_t2      = 3'b100;
  localparam logic [2:0] st_wait    = 3'b000;
  localparam logic [2:0] st_t3      = 3'b001;
  localparam logic [2:0] st_stopped = 3'b011;
  localparam logic [2:0] st_t4      = 3'b111;
  localparam logic [2:0] st_t5      = 3'b101;

  // cycle type sent in the top bits of the high address byte
  localparam logic [1:0] cyc_pci = 2'b00;
  localparam logic [1:0] cyc_pcr = 2'b10;

  // fetch cycle or operand cycle
  localparam logic mc_first  = 1'b0;
  localparam logic mc_second = 1'b1;

  // ALU group, straight from instruction bits 5:3
  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_adc = 3'd1;
  localparam logic [2:0] alu_sub = 3'd2;
  localparam logic [2:0] alu_sbb = 3'd3;
  localparam logic [2:0] alu_and = 3'd4;
  localparam logic [2:0] alu_xor = 3'd5;
  localparam logic [2:0] alu_or  = 3'd6;
  localparam logic [2:0] alu_cmp = 3'd7;

  // arithmetic group, rotates match instruction bits 5:3
  localparam logic [2:0] ar_rlc = 3'd0;
  localparam logic [2:0] ar_rrc = 3'd1;
  localparam logic [2:0] ar_ral = 3'd2;
  localparam logic [2:0] ar_rar = 3'd3;
  localparam logic [2:0] ar_inc = 3'd4;
  localparam logic [2:0] ar_dec = 3'd5;

  // scratchpad indices
  localparam logic [2:0] reg_a    = 3'd0;
  localparam logic [2:0] reg_m    = 3'd7;
  localparam int         num_regs = 7;

  // positions in the 4-bit flag word
  localparam int flag_c = 0;
  localparam int flag_z = 1;
  localparam int flag_s = 2;
  localparam int flag_p = 3;

  // internal bus sources
  localparam logic [2:0] src_none    = 3'd0;
  localparam logic [2:0] src_pc_low  = 3'd1;
  localparam logic [2:0] src_pc_high = 3'd2;
  localparam logic [2:0] src_reg     = 3'd3;
  localparam logic [2:0] src_alu     = 3'd4;
  localparam logic [2:0] src_temp_b  = 3'd5;
  localparam logic [2:0] src_din     = 3'd6;

  // instruction byte, register view and operation view
  typedef union packed {
    struct packed {
      logic [1:0] cls;
      logic [2:0] ddd;
      logic [2:0] sss;
    } r;
    struct packed {
      logic [1:0] cls;
      logic [2:0] op;
      logic [2:0] form;
    } o;
  } instr_u;

endpackage

`default_nettype wire

/* hw/i8008_scratchpad.sv */
`default_nettype none

module i8008_scratchpad (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [i8008_pkg::word_w-1:0]  bus_data,
  input  logic [i8008_pkg::sel_w-1:0]   rf_sel,
  input  logic                          rf_we,
  output logic [i8008_pkg::word_w-1:0]  rf_data,
  output logic [i8008_pkg::word_w-1:0]  acc
);

  // A, B, C, D, E, H, L
  logic [i8008_pkg::word_w-1:0] regs [i8008_pkg::num_regs];
  logic [i8008_pkg::sel_w-1:0]  rd_sel;

  // M has no storage here, reads fall back to A
  assign rd_sel = (rf_sel == i8008_pkg::reg_m) ? i8008_pkg::reg_a : rf_sel;

  always_comb begin
    rf_data = regs[rd_sel];
  end

  // accumulator tap for the ALU
  assign acc = regs[i8008_pkg::reg_a];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < i8008_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we && rf_sel != i8008_pkg::reg_m) begin
      regs[rf_sel] <= bus_data;
    end
  end

endmodule

`default_nettype wire

/* hw/i8008_alu.sv */
`default_nettype none

module i8008_alu (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [i8008_pkg::word_w-1:0]  bus_data,
  input  logic [i8008_pkg::word_w-1:0]  acc,
  input  logic                          a_load_acc,
  input  logic                          a_we,
  input  logic                          b_we,
  input  logic                          alu_arith,
  input  logic [2:0]                    alu_op,
  input  logic                          flag_we,
  output logic [i8008_pkg::word_w-1:0]  alu_data,
  output logic [i8008_pkg::word_w-1:0]  temp_b
);

  logic [i8008_pkg::word_w-1:0] temp_a;
  logic [3:0]                   flags;
  logic [3:0]                   flags_next;
  logic [i8008_pkg::word_w:0]   wide;
  logic [i8008_pkg::word_w-1:0] zsp_src;
  logic                         carry;
  logic                         is_cmp;
  logic                         keep_zsp;

  always_comb begin
    wide     = '0;
    alu_data = temp_a;
    carry    = flags[i8008_pkg::flag_c];
    is_cmp   = 1'b0;
    keep_zsp = 1'b0;
    if (alu_arith) begin
      keep_zsp = 1'b1;
      case (alu_op)
        i8008_pkg::ar_inc: begin
          alu_data = temp_a + 8'd1;
          keep_zsp = 1'b0;
        end
        i8008_pkg::ar_dec: begin
          alu_data = temp_a - 8'd1;
          keep_zsp = 1'b0;
        end
        i8008_pkg::ar_rlc: {carry, alu_data} = {temp_a[7], temp_a[6:0], temp_a[7]};
        i8008_pkg::ar_rrc: {carry, alu_data} = {temp_a[0], temp_a[0], temp_a[7:1]};
        // rotate through carry
        i8008_pkg::ar_ral: {carry, alu_data} = {temp_a, flags[i8008_pkg::flag_c]};
        i8008_pkg::ar_rar: {alu_data, carry} = {flags[i8008_pkg::flag_c], temp_a};
        default: ;
      endcase
    end else begin
      case (alu_op)
        i8008_pkg::alu_add: wide = {1'b0, temp_a} + {1'b0, temp_b};
        i8008_pkg::alu_adc: wide = {1'b0, temp_a} + {1'b0, temp_b} +
                                   {8'd0, flags[i8008_pkg::flag_c]};
        i8008_pkg::alu_sub: wide = {1'b0, temp_a} - {1'b0, temp_b};
        i8008_pkg::alu_sbb: wide = {1'b0, temp_a} - {1'b0, temp_b} -
                                   {8'd0, flags[i8008_pkg::flag_c]};
        i8008_pkg::alu_and: wide = {1'b0, temp_a & temp_b};
        i8008_pkg::alu_xor: wide = {1'b0, temp_a ^ temp_b};
        i8008_pkg::alu_or:  wide = {1'b0, temp_a | temp_b};
        default: begin
          // compare, A stays, flags come from A - B
          wide   = {1'b0, temp_a} - {1'b0, temp_b};
          is_cmp = 1'b1;
        end
      endcase
      carry    = wide[8];
      alu_data = is_cmp ? temp_a : wide[7:0];
    end
  end

  assign zsp_src = is_cmp ? wide[7:0] : alu_data;

  always_comb begin
    flags_next = flags;
    flags_next[i8008_pkg::flag_c] = carry;
    if (!keep_zsp) begin
      flags_next[i8008_pkg::flag_z] = ~|zsp_src;
      flags_next[i8008_pkg::flag_s] = zsp_src[7];
      // even parity sets P
      flags_next[i8008_pkg::flag_p] = ~^zsp_src;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      temp_a <= '0;
      temp_b <= '0;
      flags  <= '0;
    end else begin
      if (a_load_acc) begin
        temp_a <= acc;
      end else if (a_we) begin
        temp_a <= bus_data;
      end
      if (b_we) begin
        temp_b <= bus_data;
      end
      if (flag_we) begin
        flags <= flags_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/i8008_bus_unit.sv */
`default_nettype none

module i8008_bus_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          ready,
  input  logic [i8008_pkg::word_w-1:0]  d_in,
  input  logic [i8008_pkg::word_w-1:0]  rf_data,
  input  logic [i8008_pkg::word_w-1:0]  alu_data,
  input  logic [i8008_pkg::word_w-1:0]  temp_b,
  input  logic [2:0]                    bus_src,
  input  logic                          pc_inc,
  input  logic [1:0]                    cycle_type,
  output logic [i8008_pkg::word_w-1:0]  bus_data,
  output logic                          ready_sync
);

  logic                         ready_meta;
  logic [i8008_pkg::addr_w-1:0] pc;

  // two-flop READY synchronizer
  always_ff @(posedge clk) begin
    if (rst) begin
      ready_meta <= 1'b0;
      ready_sync <= 1'b0;
    end else begin
      ready_meta <= ready;
      ready_sync <= ready_meta;
    end
  end

  // bumped at the end of T2, after both address bytes went out
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (pc_inc) begin
      pc <= pc + 14'd1;
    end
  end

  always_comb begin
    case (bus_src)
      i8008_pkg::src_pc_low:  bus_data = pc[7:0];
      // cycle type rides in bits 7:6
      i8008_pkg::src_pc_high: bus_data = {cycle_type, pc[i8008_pkg::addr_w-1:8]};
      i8008_pkg::src_reg:     bus_data = rf_data;
      i8008_pkg::src_alu:     bus_data = alu_data;
      i8008_pkg::src_temp_b:  bus_data = temp_b;
      i8008_pkg::src_din:     bus_data = d_in;
      default:                bus_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/i8008_control.sv */
`default_nettype none

module i8008_control (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [i8008_pkg::word_w-1:0]    bus_data,
  input  logic                            ready_sync,
  output logic [i8008_pkg::state_w-1:0]   state,
  output logic [2:0]                      bus_src,
  output logic                            pc_inc,
  output logic [1:0]                      cycle_type,
  output logic [i8008_pkg::sel_w-1:0]     rf_sel,
  output logic                            rf_we,
  output logic                            a_load_acc,
  output logic                            a_we,
  output logic                            b_we,
  output logic                            alu_arith,
  output logic [2:0]                      alu_op,
  output logic                            flag_we
);

  i8008_pkg::instr_u                ir;
  i8008_pkg::instr_u                fetched;
  logic                             cycle;
  logic                             next_cycle;
  logic [i8008_pkg::state_w-1:0]    next_state;
  logic                             dec_move;
  logic                             dec_ldi;
  logic                             dec_alu_reg;
  logic                             dec_alu_imm;
  logic                             dec_inc;
  logic                             dec_dec;
  logic                             dec_rot;

  function automatic logic is_hlt(i8008_pkg::instr_u i);
    return (i == 8'h00) || (i == 8'h01) || (i == 8'hff);
  endfunction

  // LrI and the ALU immediate forms need an operand cycle
  function automatic logic is_imm(i8008_pkg::instr_u i);
    return (i.o.cls == 2'b00) && ((i.o.form == 3'b100) || (i.o.form == 3'b110));
  endfunction

  // byte arriving at T3 is decoded before it reaches ir
  assign fetched = bus_data;

  assign dec_move    = (ir.r.cls == 2'b11) && !is_hlt(ir);
  assign dec_alu_reg = ir.o.cls == 2'b10;
  assign dec_alu_imm = (ir.o.cls == 2'b00) && (ir.o.form == 3'b100);
  assign dec_ldi     = (ir.r.cls == 2'b00) && (ir.r.sss == 3'b110);
  assign dec_inc     = (ir.r.cls == 2'b00) && (ir.r.sss == 3'b000) &&
                       (ir.r.ddd != i8008_pkg::reg_a);
  assign dec_dec     = (ir.r.cls == 2'b00) && (ir.r.sss == 3'b001) &&
                       (ir.r.ddd != i8008_pkg::reg_a);
  assign dec_rot     = (ir.o.cls == 2'b00) && (ir.o.form == 3'b010) && !ir.o.op[2];

  assign cycle_type = (cycle == i8008_pkg::mc_second) ? i8008_pkg::cyc_pcr
                                                      : i8008_pkg::cyc_pci;

  // state sequencing
  always_comb begin
    next_state = i8008_pkg::st_t1;
    next_cycle = i8008_pkg::mc_first;
    case (state)
      i8008_pkg::st_t1: begin
        next_state = i8008_pkg::st_t2;
        next_cycle = cycle;
      end
      i8008_pkg::st_t2, i8008_pkg::st_wait: begin
        next_state = ready_sync ? i8008_pkg::st_t3 : i8008_pkg::st_wait;
        next_cycle = cycle;
      end
      i8008_pkg::st_t3: begin
        if (cycle == i8008_pkg::mc_second) begin
          next_state = i8008_pkg::st_t4;
          next_cycle = cycle;
        end else if (is_hlt(fetched)) begin
          next_state = i8008_pkg::st_stopped;
        end else if (is_imm(fetched)) begin
          next_cycle = i8008_pkg::mc_second;
        end else begin
          next_state = i8008_pkg::st_t4;
        end
      end
      i8008_pkg::st_t4: begin
        next_state = i8008_pkg::st_t5;
        next_cycle = cycle;
      end
      // only reset leaves STOPPED
      i8008_pkg::st_stopped: begin
        next_state = i8008_pkg::st_stopped;
        next_cycle = cycle;
      end
      default: ;
    endcase
  end

  // per-state strobes
  always_comb begin
    bus_src    = i8008_pkg::src_none;
    pc_inc     = 1'b0;
    rf_sel     = i8008_pkg::reg_a;
    rf_we      = 1'b0;
    a_load_acc = 1'b0;
    a_we       = 1'b0;
    b_we       = 1'b0;
    alu_arith  = 1'b0;
    alu_op     = ir.o.op;
    flag_we    = 1'b0;
    case (state)
      i8008_pkg::st_t1: bus_src = i8008_pkg::src_pc_low;
      i8008_pkg::st_t2: begin
        bus_src = i8008_pkg::src_pc_high;
        pc_inc  = 1'b1;
      end
      i8008_pkg::st_t3: begin
        bus_src = i8008_pkg::src_din;
        b_we    = cycle == i8008_pkg::mc_second;
      end
      i8008_pkg::st_t4: begin
        if (cycle == i8008_pkg::mc_first && (dec_move || dec_alu_reg)) begin
          bus_src = i8008_pkg::src_reg;
          rf_sel  = ir.r.sss;
          b_we    = 1'b1;
        end
        if (cycle == i8008_pkg::mc_first && (dec_inc || dec_dec)) begin
          bus_src = i8008_pkg::src_reg;
          rf_sel  = ir.r.ddd;
          a_we    = 1'b1;
        end
        a_load_acc = (cycle == i8008_pkg::mc_first) ? (dec_alu_reg || dec_rot) : dec_alu_imm;
      end
      i8008_pkg::st_t5: begin
        if (dec_move || dec_ldi) begin
          bus_src = i8008_pkg::src_temp_b;
          rf_sel  = ir.r.ddd;
          rf_we   = 1'b1;
        end else if (dec_alu_reg || dec_alu_imm || dec_rot) begin
          bus_src   = i8008_pkg::src_alu;
          rf_we     = 1'b1;
          flag_we   = 1'b1;
          alu_arith = dec_rot;
        end else if (dec_inc || dec_dec) begin
          bus_src   = i8008_pkg::src_alu;
          rf_sel    = ir.r.ddd;
          rf_we     = 1'b1;
          flag_we   = 1'b1;
          alu_arith = 1'b1;
          alu_op    = dec_dec ? i8008_pkg::ar_dec : i8008_pkg::ar_inc;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= i8008_pkg::st_t1;
      cycle <= i8008_pkg::mc_first;
      ir    <= '0;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
      if (state == i8008_pkg::st_t3 && cycle == i8008_pkg::mc_first) begin
        ir <= fetched;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/i8008_cpu.sv */
`default_nettype none

module i8008_cpu (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [i8008_pkg::word_w-1:0]    d_in,
  input  logic                            ready,
  output logic [i8008_pkg::word_w-1:0]    d_out,
  output logic [i8008_pkg::state_w-1:0]   state
);

  logic                          ready_sync;
  logic [2:0]                    bus_src;
  logic                          pc_inc;
  logic [1:0]                    cycle_type;
  logic [i8008_pkg::sel_w-1:0]   rf_sel;
  logic                          rf_we;
  logic [i8008_pkg::word_w-1:0]  rf_data;
  logic [i8008_pkg::word_w-1:0]  acc;
  logic                          a_load_acc;
  logic                          a_we;
  logic                          b_we;
  logic                          alu_arith;
  logic [2:0]                    alu_op;
  logic                          flag_we;
  logic [i8008_pkg::word_w-1:0]  alu_data;
  logic [i8008_pkg::word_w-1:0]  temp_b;

  i8008_control u_control (
    .clk, .rst,
    .bus_data (d_out),
    .ready_sync,
    .state,
    .bus_src, .pc_inc, .cycle_type,
    .rf_sel, .rf_we,
    .a_load_acc, .a_we, .b_we, .alu_arith, .alu_op, .flag_we
  );

  i8008_scratchpad u_scratchpad (
    .clk, .rst,
    .bus_data (d_out),
    .rf_sel, .rf_we,
    .rf_data, .acc
  );

  i8008_alu u_alu (
    .clk, .rst,
    .bus_data (d_out),
    .acc,
    .a_load_acc, .a_we, .b_we, .alu_arith, .alu_op, .flag_we,
    .alu_data, .temp_b
  );

  // the internal bus is the data output pin
  i8008_bus_unit u_bus_unit (
    .clk, .rst,
    .ready, .d_in, .rf_data, .alu_data, .temp_b,
    .bus_src, .pc_inc, .cycle_type,
    .bus_data (d_out),
    .ready_sync
  );

endmodule

`default_nettype wire

/* verif/i8008_cpu_tb.sv */
`default_nettype none

module i8008_cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_recs   = 31;
  localparam int clk_half   = 10;
  localparam int rst_cycles = 10;
  localparam int stop_clks  = 20;
  // two machine cycles of at most 12 clocks per instruction plus reset
  localparam int limit_clks = num_recs * 2 * 12 + rst_cycles;

  logic                            clk;
  logic                            rst;
  logic [i8008_pkg::word_w-1:0]    d_in;
  logic                            ready;
  logic [i8008_pkg::word_w-1:0]    d_out;
  logic [i8008_pkg::state_w-1:0]   state;

  // golden file holds three bytes per record
  logic [7:0] golden_raw [num_recs * 3];
  logic [7:0] rec_op     [num_recs];
  logic [7:0] rec_arg    [num_recs];
  logic [7:0] rec_exp    [num_recs];
  logic [7:0] image      [2 ** i8008_pkg::addr_w];
  integer     seed = 62461;
  int         errors;
  int         passed;
  int         failed;

  i8008_cpu u_i8008_cpu (
    .clk   (clk),
    .rst   (rst),
    .d_in  (d_in),
    .ready (ready),
    .d_out (d_out),
    .state (state)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  initial begin
    #(limit_clks * 2 * clk_half);
    $display("timeout: the program did not reach its end within %0d clocks", limit_clks);
    $display("TB FAILED");
    $finish;
  end

  // LrI and the ALU immediates take a second byte
  function automatic logic has_operand(input logic [7:0] opcode);
    return (opcode[7:6] == 2'b00) && opcode[2] && !opcode[0];
  endfunction

  task automatic check_byte(input string name, input logic [i8008_pkg::word_w-1:0] got,
                            input logic [i8008_pkg::word_w-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s = %02h, expected %02h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_state(input string name, input logic [i8008_pkg::state_w-1:0] got,
                             input logic [i8008_pkg::state_w-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s = %03b, expected %03b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input logic [7:0] opcode, input logic ok);
    if (ok) begin
      passed++;
      $display("test %0d, opcode %02h: ok", num, opcode);
    end else begin
      failed++;
      $display("test %0d, opcode %02h: mismatch", num, opcode);
    end
  endtask

  // program image at consecutive addresses from 0
  task automatic load_program();
    int addr;
    for (int a = 0; a < 2 ** i8008_pkg::addr_w; a++) begin
      image[a] = a[7:0] ^ {2'b00, a[13:8]} ^ 8'h5a;
    end
    $readmemh("verif/i8008_golden.mem", golden_raw);
    addr = 0;
    for (int r = 0; r < num_recs; r++) begin
      rec_op[r]  = golden_raw[r * 3];
      rec_arg[r] = golden_raw[r * 3 + 1];
      rec_exp[r] = golden_raw[r * 3 + 2];
      image[addr] = rec_op[r];
      addr++;
      if (has_operand(rec_op[r])) begin
        image[addr] = rec_arg[r];
        addr++;
      end
    end
    if (rec_op[num_recs - 1] != 8'hff) begin
      $display("golden file does not end with a HLT instruction");
      errors++;
    end
  endtask

  initial begin
    logic [i8008_pkg::state_w-1:0] cur;
    logic [i8008_pkg::state_w-1:0] exp_next;
    logic                          next_known;
    logic [13:0]                   exp_addr;
    logic [13:0]                   cap_addr;
    logic [7:0]                    exp_high;
    logic [7:0]                    din_next;
    logic                          operand_cycle;
    logic                          halted;
    logic                          aborted;
    logic [31:0]                   rnd;
    int                            idx;
    int                            waits;
    int                            test_err0;

    errors = 0;
    passed = 0;
    failed = 0;
    rst    = 1'b1;
    ready  = 1'b1;
    d_in   = '0;
    load_program();

    repeat (rst_cycles) @(negedge clk);
    rst = 1'b0;

    exp_addr      = '0;
    cap_addr      = '0;
    exp_next      = i8008_pkg::st_t1;
    next_known    = 1'b1;
    operand_cycle = 1'b0;
    halted        = 1'b0;
    aborted       = 1'b0;
    idx           = 0;
    waits         = 0;
    test_err0     = 0;

    while (!halted && !aborted) begin
      cur = state;
      rnd = $random(seed);
      din_next = rnd[15:8];
      if (next_known) begin
        check_state("state", cur, exp_next);
      end else if (cur !== i8008_pkg::st_wait && cur !== i8008_pkg::st_t3) begin
        $display("CHECK FAILED at %0t: state = %03b, expected %03b or %03b", $time, cur,
                 i8008_pkg::st_wait, i8008_pkg::st_t3);
        errors++;
      end
      next_known = 1'b1;
      case (cur)
        i8008_pkg::st_t1: begin
          if (!operand_cycle) begin
            test_err0 = errors;
          end
          cap_addr[7:0] = d_out;
          check_byte("d_out at T1", d_out, exp_addr[7:0]);
          exp_next = i8008_pkg::st_t2;
        end
        i8008_pkg::st_t2: begin
          cap_addr[13:8] = d_out[5:0];
          exp_high = {operand_cycle ? i8008_pkg::cyc_pcr : i8008_pkg::cyc_pci,
                      exp_addr[13:8]};
          check_byte("d_out at T2", d_out, exp_high);
          next_known = 1'b0;
        end
        i8008_pkg::st_wait: begin
          waits++;
          next_known = 1'b0;
        end
        i8008_pkg::st_t3: begin
          din_next = image[cap_addr];
          exp_addr++;
          if (operand_cycle) begin
            operand_cycle = 1'b0;
            exp_next = i8008_pkg::st_t4;
          end else if (rec_op[idx] == 8'hff) begin
            exp_next = i8008_pkg::st_stopped;
            halted = 1'b1;
          end else if (has_operand(rec_op[idx])) begin
            operand_cycle = 1'b1;
            exp_next = i8008_pkg::st_t1;
          end else begin
            exp_next = i8008_pkg::st_t4;
          end
        end
        i8008_pkg::st_t4: exp_next = i8008_pkg::st_t5;
        i8008_pkg::st_t5: begin
          check_byte("d_out at T5", d_out, rec_exp[idx]);
          report_test(idx, rec_op[idx], errors == test_err0);
          idx++;
          exp_next = i8008_pkg::st_t1;
        end
        default: begin
          $display("core entered state %03b at %0t before the final HLT", cur, $time);
          errors++;
          aborted = 1'b1;
        end
      endcase
      d_in  = din_next;
      ready = rnd[1:0] != 2'b00;
      @(negedge clk);
    end

    // halted core must hold STOPPED with no new T1
    if (!aborted) begin
      for (int i = 0; i <= stop_clks; i++) begin
        check_state("state after HLT", state, i8008_pkg::st_stopped);
        rnd   = $random(seed);
        d_in  = rnd[15:8];
        ready = rnd[1:0] != 2'b00;
        @(negedge clk);
      end
      report_test(idx, rec_op[idx], errors == test_err0);
    end
    if (waits == 0) begin
      $display("READY never held the core in WAIT");
      errors++;
    end

    $display("%0d tests passed, %0d tests failed, %0d check errors, %0d wait states",
             passed, failed, errors, waits);
    if (errors == 0 && failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/i8008_golden.mem */
// opcode  operand  expected d_out at T5
// operand is 00 where the instruction has none, last record is HLT
06 3c 3c  // LAI 3C
0e d5 d5  // LBI D5
d0 00 3c  // LCA
81 00 11  // ADB, carry set
8a 00 4e  // ACC with carry in
91 00 79  // SUB, borrow set
9a 00 3c  // SBC with borrow in
a1 00 14  // NDB
a9 00 c1  // XRB
b2 00 fd  // ORC
b9 00 fd  // CPB, A unchanged
04 05 02  // ADI 05, carry set
0c 10 13  // ACI 10 with carry in
14 20 f3  // SUI 20, borrow set
1c 03 ef  // SBI 03 with borrow in
24 7e 6e  // NDI 7E
2c ff 91  // XRI FF
34 04 95  // ORI 04, carry clear
3c a0 95  // CPI A0, carry set
0a 00 ca  // RRC
1a 00 e5  // RAR with carry 1
12 00 ca  // RAL with carry 0
02 00 95  // RLC
08 00 d6  // INB
11 00 3b  // DCC
26 80 80  // LEI 80
21 00 7f  // DCE
c4 00 7f  // LAE
28 00 01  // INH
85 00 80  // ADH
ff 00 00  // HLT

/* sources.f */
hw/i8008_pkg.sv
hw/i8008_scratchpad.sv
hw/i8008_alu.sv
hw/i8008_bus_unit.sv
hw/i8008_control.sv
hw/i8008_cpu.sv
verif/i8008_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the i8008 testbench with Verilator, then scan the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f sources.f \
  --top-module i8008_cpu_tb -o i8008_sim \
  && ./obj_dir/i8008_sim > sim.log 2>&1 \
  || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
